// File: logic/mcontr_cfg.svh
// ddr3 write-command sequencer configuration
// encoder count, downstream credit depth, address widths and pause word layout
`ifndef MCONTR_CFG_SVH
`define MCONTR_CFG_SVH

// number of linear-write encoders working side by side
// keep a power of two so the order fifo pointers wrap cleanly
`define MC_NUM_ENC 4

// command memory slots downstream, also the credit counter reset value
`define MC_CREDITS 4

// row address width, the full addr field of a command word
`define MC_ROW_BITS 15

// column address width in 16-bit units
// burst column drops the 3 lsbs, one burst of 8 is 128 bits
`define MC_COL_BITS 10

// pause word layout
// a nop word reuses its addr field as skip count plus done flag
`define MC_PAUSE_BITS 10 // skip count in addr[9:0]
`define MC_DONE_BIT 10 // end of sequence marker in addr[10]

// bits of addr above the done flag stay zero in a pause word
// skip values used here are 0 and 2, more cycles are a controller matter
// a write word carries the burst column shifted left by 3 in addr
// activate and precharge carry the row in addr

`endif

// File: logic/mcontr_pkg.sv
// shared types of the ddr3 write-command sequencer
// request layout, encoded command word layout and rcw command codes
`default_nettype none

`include "mcontr_cfg.svh"

package mcontr_pkg;

    typedef logic [`MC_ROW_BITS-1:0] row_addr_t; // row, also the full addr field
    typedef logic [`MC_COL_BITS-4:0] col_addr_t; // burst column, 7 bits
    typedef logic [2:0] bank_t; // ddr3 bank
    typedef logic [5:0] burst_cnt_t; // number of 128-bit bursts, 0 means 64
    typedef logic [$clog2(`MC_NUM_ENC)-1:0] enc_idx_t; // encoder number
    typedef logic [$clog2(`MC_CREDITS+1)-1:0] credit_cnt_t; // 0..MC_CREDITS
    typedef logic [2:0] rcw_t; // ras/cas/we, positive logic
    typedef logic [`MC_PAUSE_BITS-1:0] pause_t; // skip count of a pause word

    // rcw codes of the command word
    localparam rcw_t RCW_NOP = 3'd0;
    localparam rcw_t RCW_WRITE = 3'd3;
    localparam rcw_t RCW_ACTIVATE = 3'd4;
    localparam rcw_t RCW_PRECHARGE = 3'd5;

    // one page-write request from the host
    typedef struct packed {
        bank_t      bank; // target bank
        row_addr_t  row; // row to open
        col_addr_t  start_col; // first burst column
        burst_cnt_t num128; // bursts to write
    } wr_req_t;

    // encoded 32-bit word for the command memory, msb first
    typedef struct packed {
        row_addr_t addr; // row, column<<3 or pause skip/done
        bank_t     bank;
        rcw_t      rcw;
        logic      odt_en; // enable odt
        logic      cke; // always 0 here
        logic      sel; // command in second half-cycle
        logic      dq_en; // drive dq lines
        logic      dqs_en; // drive dqs lines
        logic      dqs_toggle; // toggle dqs by pattern
        logic      dci; // always 0 here
        logic      buf_wr; // always 0 here
        logic      buf_rd; // read from data buffer
        logic      nop; // nop slot after this command
        logic      buf_rst; // buffer to next page
    } seq_cmd_t;

endpackage

`default_nettype wire

// File: logic/wr_req_dispatch.sv
// write request dispatcher
// accepts host requests and starts the next idle encoder in round-robin order
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module wr_req_dispatch
    import mcontr_pkg::*;
(
    input  logic                   rst, // clock
    input  logic                   clk, // async reset, active high
    input  wr_req_t                req, // request from host
    input  logic                   req_valid,
    output logic                   req_ready, // some encoder free
    input  logic [`MC_NUM_ENC-1:0] idle, // per encoder
    output logic [`MC_NUM_ENC-1:0] start, // one-cycle start pulse
    output wr_req_t                enc_req // registered request for started encoder
);

    logic [`MC_NUM_ENC-1:0] free; // idle and not being started right now
    enc_idx_t               ptr; // round-robin search origin
    enc_idx_t               pick; // chosen encoder
    enc_idx_t               cand;
    logic                   accept;

    // encoder started this cycle still shows idle until the next edge
    assign free = idle & ~start;
    assign req_ready = |free;
    assign accept = req_valid & req_ready;

    // first free encoder at or after ptr
    // scan backwards so the nearest hit is written last
    always_comb begin
        pick = ptr;
        cand = ptr;
        for (int i = `MC_NUM_ENC - 1; i >= 0; i--) begin
            cand = enc_idx_t'((int'(ptr) + i) % `MC_NUM_ENC);
            if (free[cand]) begin
                pick = cand; // nearer candidate wins
            end
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            ptr <= '0;
            start <= '0;
        end else begin
            start <= '0; // pulse lasts one cycle
            if (accept) begin
                start[pick] <= 1'b1;
                // move past the chosen encoder to spread load
                ptr <= (pick == enc_idx_t'(`MC_NUM_ENC - 1)) ? '0 : pick + 1'b1;
            end
        end
    end

    // request payload, valid together with start
    always_ff @(posedge rst) begin
        if (accept) begin
            enc_req <= req;
        end
    end

endmodule

`default_nettype wire

// File: logic/linear_wr_encoder.sv
// linear page write encoder
// turns one page-write request into activate, writes, pauses, precharge
// and a final done pause, one 32-bit command word per take
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module linear_wr_encoder
    import mcontr_pkg::*;
(
    input  logic     rst, // clock
    input  logic     clk, // async reset, active high
    input  logic     start, // load request, only while idle
    input  wr_req_t  enc_req,
    output logic     idle,
    output seq_cmd_t word, // current command word
    output logic     word_valid, // word held until take
    input  logic     take // merger consumed word
);

    typedef logic [3:0] rom_addr_t;

    // one sequence step
    typedef struct packed {
        rcw_t       rcw;
        logic [1:0] skip; // pause cycles for nop entries
        logic       done; // last word of the sequence
        logic       odt;
        logic       sel;
        logic       dq_dqs; // dq_en and dqs_en together
        logic       toggle; // dqs_toggle
        logic       buf_rd;
        logic       buf_rst;
        logic       nop;
    } rom_t;

    localparam rom_addr_t LOOP_ADDR = 4'd4; // repeated write
    localparam rom_addr_t LAST_ADDR = 4'd9; // done pause

    logic       busy;
    logic       adv; // step on take
    rom_addr_t  rom_addr; // registered sequence position
    burst_cnt_t rep; // writes still to come at LOOP_ADDR
    col_addr_t  col; // burst column of the next write
    row_addr_t  row_r;
    bank_t      bank_r;
    rom_t       rom;

    assign idle = ~busy;
    assign word_valid = busy;
    assign adv = take & busy;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            busy <= 1'b0;
            rom_addr <= '0;
            rep <= '0;
        end else if (start) begin
            busy <= 1'b1;
            rom_addr <= '0;
            rep <= burst_cnt_t'(enc_req.num128 - 1'b1); // 0 wraps to 63 for 64 bursts
        end else if (adv) begin
            if (rom_addr == LAST_ADDR) begin
                busy <= 1'b0; // done word taken
            end else if (rom_addr == LOOP_ADDR - 1'b1) begin
                // single burst skips the loop
                rom_addr <= (rep == '0) ? LOOP_ADDR + 1'b1 : LOOP_ADDR;
            end else if (rom_addr == LOOP_ADDR) begin
                rep <= rep - 1'b1;
                if (rep == burst_cnt_t'(1)) begin
                    rom_addr <= rom_addr + 1'b1; // last repeated write
                end
            end else begin
                rom_addr <= rom_addr + 1'b1;
            end
        end
    end

    // request fields and column counter
    always_ff @(posedge rst) begin
        if (start) begin
            row_r <= enc_req.row;
            bank_r <= enc_req.bank;
            col <= enc_req.start_col;
        end else if (adv && rom.rcw == RCW_WRITE) begin
            col <= col + 1'b1; // wraps mod 128
        end
    end

    // sequence rom
    always_comb begin
        rom = '0;
        case (rom_addr)
            4'd0: begin // activate row
                rom.rcw = RCW_ACTIVATE;
                rom.nop = 1'b1;
            end
            4'd1: rom.buf_rd = 1'b1; // prefetch from buffer
            4'd2: begin // first write
                rom.rcw = RCW_WRITE;
                rom.sel = 1'b1;
                rom.odt = 1'b1;
            end
            4'd3: begin // dq/dqs turn on
                rom.dq_dqs = 1'b1;
                rom.odt = 1'b1;
            end
            LOOP_ADDR: begin // further writes, repeated n-1 times
                rom.rcw = RCW_WRITE;
                rom.toggle = 1'b1;
                rom.dq_dqs = 1'b1;
                rom.odt = 1'b1;
                rom.buf_rd = 1'b1;
            end
            4'd5, 4'd6, 4'd8: rom.skip = 2'd2; // write recovery and precharge pauses
            4'd7: begin
                rom.rcw = RCW_PRECHARGE;
                rom.buf_rst = 1'b1; // buffer moves to next page
            end
            LAST_ADDR: rom.done = 1'b1;
            default: rom = '0;
        endcase
    end

    // command word from rom bits and request fields
    always_comb begin
        word = '0; // cke, dci, buf_wr stay zero
        word.bank = bank_r;
        word.rcw = rom.rcw;
        word.odt_en = rom.odt;
        word.sel = rom.sel;
        word.dq_en = rom.dq_dqs;
        word.dqs_en = rom.dq_dqs;
        word.dqs_toggle = rom.toggle;
        word.buf_rd = rom.buf_rd;
        word.buf_rst = rom.buf_rst;
        word.nop = rom.nop;
        case (rom.rcw)
            RCW_NOP: begin // pause format
                word.addr[`MC_PAUSE_BITS-1:0] = pause_t'(rom.skip);
                word.addr[`MC_DONE_BIT] = rom.done;
            end
            RCW_WRITE: word.addr = row_addr_t'({col, 3'b000});
            default: word.addr = row_r; // activate, precharge
        endcase
    end

endmodule

`default_nettype wire

// File: logic/enc_cmd_merge.sv
// encoder output merger
// drains whole sequences in start order and meters words with downstream credits
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module enc_cmd_merge
    import mcontr_pkg::*;
(
    input  logic                   rst, // clock
    input  logic                   clk, // async reset, active high
    input  logic [`MC_NUM_ENC-1:0] start, // encoder start pulses from dispatcher
    input  seq_cmd_t               word [`MC_NUM_ENC],
    input  logic [`MC_NUM_ENC-1:0] word_valid,
    output logic [`MC_NUM_ENC-1:0] take,
    output seq_cmd_t               cmd, // to command memory
    output logic                   cmd_valid,
    output logic                   seq_done, // with the done word
    input  logic                   credit_return // one slot freed downstream
);

    localparam int CNT_W = $clog2(`MC_NUM_ENC + 1);

    enc_idx_t    fifo_mem [`MC_NUM_ENC]; // started encoders, oldest first
    enc_idx_t    wr_ptr;
    enc_idx_t    rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    enc_idx_t    start_idx;
    enc_idx_t    head; // encoder allowed to send
    seq_cmd_t    head_word;
    logic        push;
    logic        pop;
    logic        take_any;
    logic        word_done;
    credit_cnt_t credits;
    logic        credit_ok;

    // at most one start per cycle
    always_comb begin
        start_idx = '0;
        for (int i = 0; i < `MC_NUM_ENC; i++) begin
            if (start[i]) start_idx = enc_idx_t'(i);
        end
    end

    assign push = |start;
    assign head = fifo_mem[rd_ptr];
    assign head_word = word[head];
    // word on the output register already owns one credit
    assign credit_ok = credits > credit_cnt_t'(cmd_valid);
    assign take_any = (fifo_cnt != '0) & word_valid[head] & credit_ok;
    assign word_done = (head_word.rcw == RCW_NOP) & head_word.addr[`MC_DONE_BIT];
    assign pop = take_any & word_done; // sequence finished, next encoder

    always_comb begin
        take = '0;
        take[head] = take_any;
    end

    always_ff @(posedge rst) begin
        if (push) fifo_mem[wr_ptr] <= start_idx;
        if (take_any) cmd <= head_word;
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_cnt <= '0;
            credits <= credit_cnt_t'(`MC_CREDITS);
            cmd_valid <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: fifo_cnt <= fifo_cnt + 1'b1;
                2'b01: fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt; // none or both
            endcase
            // sent word spends, returned slot refills
            case ({cmd_valid, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            cmd_valid <= take_any;
            seq_done <= pop;
        end
    end

endmodule

`default_nettype wire

// File: logic/wr_seq_top.sv
// ddr3 write-command sequencer top
// dispatcher, a row of linear-write encoders and the ordered merger
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module wr_seq_top
    import mcontr_pkg::*;
(
    input  logic     rst, // clock
    input  logic     clk, // async reset, active high
    input  wr_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output seq_cmd_t cmd,
    output logic     cmd_valid,
    output logic     seq_done,
    input  logic     credit_return
);

    logic [`MC_NUM_ENC-1:0] idle;
    logic [`MC_NUM_ENC-1:0] start;
    logic [`MC_NUM_ENC-1:0] word_valid;
    logic [`MC_NUM_ENC-1:0] take;
    wr_req_t                enc_req; // shared, only the started encoder latches it
    seq_cmd_t               word [`MC_NUM_ENC];

    wr_req_dispatch u_dispatch (
        .rst       (rst),
        .clk       (clk),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .idle      (idle),
        .start     (start),
        .enc_req   (enc_req)
    );

    for (genvar g = 0; g < `MC_NUM_ENC; g++) begin : g_enc
        linear_wr_encoder u_enc (
            .rst        (rst),
            .clk        (clk),
            .start      (start[g]),
            .enc_req    (enc_req),
            .idle       (idle[g]),
            .word       (word[g]),
            .word_valid (word_valid[g]),
            .take       (take[g])
        );
    end

    enc_cmd_merge u_merge (
        .rst           (rst),
        .clk           (clk),
        .start         (start),
        .word          (word),
        .word_valid    (word_valid),
        .take          (take),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .seq_done      (seq_done),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: tb/wr_seq_props.sv
// merger properties for the ddr3 write-command sequencer
// credit use, credit bound and encoder word hold until take
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module wr_seq_props
    import mcontr_pkg::*;
(
    input logic                   rst, // clock
    input logic                   clk, // async reset, active high
    input logic                   cmd_valid,
    input credit_cnt_t            credits,
    input logic [`MC_NUM_ENC-1:0] word_valid,
    input logic [`MC_NUM_ENC-1:0] take,
    input seq_cmd_t               word [`MC_NUM_ENC]
);

    int unsigned fail_cnt = 0; // failed property count, read by the testbench

    // word on the output always owns a credit
    a_spend: assert property (@(posedge rst) disable iff (clk) cmd_valid |-> credits != '0)
        else begin
            fail_cnt++;
            $error("cmd_valid with zero credits");
        end

    // returns never outnumber the words sent
    a_bound: assert property (@(posedge rst) disable iff (clk)
        credits <= credit_cnt_t'(`MC_CREDITS))
        else begin
            fail_cnt++;
            $error("credit count above MC_CREDITS");
        end

    for (genvar g = 0; g < `MC_NUM_ENC; g++) begin : g_hold
        // encoder holds its word until the merger takes it
        a_hold: assert property (@(posedge rst) disable iff (clk)
            word_valid[g] && !take[g] |=> word_valid[g] && $stable(word[g]))
            else begin
                fail_cnt++;
                $error("encoder %0d changed its word before take", g);
            end
    end

endmodule

bind enc_cmd_merge wr_seq_props u_props (
    .rst        (rst),
    .clk        (clk),
    .cmd_valid  (cmd_valid),
    .credits    (credits),
    .word_valid (word_valid),
    .take       (take),
    .word       (word)
);

`default_nettype wire

// File: tb/wr_seq_tb.sv
// testbench of the ddr3 write-command sequencer
// directed and random page writes, a credit-returning command memory model
// and a word-by-word reference of every accepted request
`timescale 1ns/1ps
`default_nettype none

`include "mcontr_cfg.svh"

module wr_seq_tb
    import mcontr_pkg::*;
();

    localparam int NUM_REQ = 17; // 1 + 2 directed, 8 + 6 random
    localparam logic [31:0] SEED = 32'h5f87_8de2;
    localparam logic [31:0] POLY = 32'h8020_0003; // x^32+x^22+x^2+x+1

    logic     rst; // clock
    logic     clk; // reset
    wr_req_t  req;
    logic     req_valid;
    logic     req_ready;
    seq_cmd_t cmd;
    logic     cmd_valid;
    logic     seq_done;
    logic     credit_return;

    logic [31:0] lfsr;
    wr_req_t     reqs [NUM_REQ];
    seq_cmd_t    exp_q [$]; // expected words in acceptance order
    logic        exp_last [$]; // seq_done expected with each word
    seq_cmd_t    ds_q [$]; // downstream command memory
    int          drain_mode; // 0 every cycle, 1 random, 2 long holds
    int          hold_cnt;
    int          errors;
    int          tests_run;
    int          tests_bad;
    int          cycle_cnt;
    int          cycle_limit;
    logic        busy_seen; // req_ready seen low

    wr_seq_top dut0 (
        .rst           (rst),
        .clk           (clk),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .seq_done      (seq_done),
        .credit_return (credit_return)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ POLY) : (s >> 1); // galois step to the right
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]}; // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic void check_value(input string name, input logic [31:0] exp_v,
                                        input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endfunction

    function automatic seq_cmd_t make_word(input bank_t b, input rcw_t c, input row_addr_t a);
        seq_cmd_t w;
        w = '0; // cke, dci, buf_wr never set
        w.bank = b;
        w.rcw = c;
        w.addr = a;
        return w;
    endfunction

    function automatic void push_word(input seq_cmd_t w, input logic last);
        exp_q.push_back(w);
        exp_last.push_back(last);
    endfunction

    // n+8 words of one page write
    function automatic void expect_request(input wr_req_t r);
        seq_cmd_t w;
        int n;
        n = (r.num128 == '0) ? 64 : int'(r.num128);
        w = make_word(r.bank, RCW_ACTIVATE, r.row);
        w.nop = 1'b1;
        push_word(w, 1'b0);
        w = make_word(r.bank, RCW_NOP, '0);
        w.buf_rd = 1'b1;
        push_word(w, 1'b0);
        for (int k = 0; k < n; k++) begin
            w = make_word(r.bank, RCW_WRITE, row_addr_t'(((int'(r.start_col) + k) % 128) * 8));
            w.odt_en = 1'b1;
            w.sel = (k == 0); // first write only
            w.dq_en = (k != 0);
            w.dqs_en = (k != 0);
            w.dqs_toggle = (k != 0);
            w.buf_rd = (k != 0);
            push_word(w, 1'b0);
            if (k == 0) begin
                w = make_word(r.bank, RCW_NOP, '0); // dq/dqs turn on
                w.odt_en = 1'b1;
                w.dq_en = 1'b1;
                w.dqs_en = 1'b1;
                push_word(w, 1'b0);
            end
        end
        for (int p = 0; p < 4; p++) begin
            // pause 2, pause 2, precharge, pause 2
            w = (p == 2) ? make_word(r.bank, RCW_PRECHARGE, r.row) : make_word(r.bank, RCW_NOP, 2);
            w.buf_rst = (p == 2);
            push_word(w, 1'b0);
        end
        push_word(make_word(r.bank, RCW_NOP, row_addr_t'(1 << `MC_DONE_BIT)), 1'b1);
    endfunction

    function automatic void build_requests();
        reqs[0] = '{bank: 3'd2, row: 15'h1a5c, start_col: 7'd10, num128: 6'd1};
        reqs[1] = '{bank: 3'd5, row: 15'h7001, start_col: 7'd125, num128: 6'd5}; // wraps
        reqs[2] = '{bank: 3'd0, row: 15'h0420, start_col: 7'd100, num128: 6'd0}; // 64 bursts
        for (int i = 3; i < NUM_REQ; i++) begin
            reqs[i].bank = bank_t'(rand_bits(3));
            reqs[i].row = row_addr_t'(rand_bits(15));
            reqs[i].start_col = col_addr_t'(rand_bits(7));
            if (i < 11) begin
                reqs[i].num128 = burst_cnt_t'(rand_bits(6));
            end else begin
                reqs[i].num128 = burst_cnt_t'(rand_bits(4) + 1); // short runs for held credits
            end
        end
    endfunction

    // called and returning just after a falling edge
    task automatic send_req(input wr_req_t r);
        req = r;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge rst);
        end
        expect_request(r); // transfer on the next rising edge
        @(negedge rst);
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || ds_q.size() != 0) begin
            @(negedge rst);
        end
        repeat (4) @(negedge rst); // room for a stray word
    endtask

    task automatic report_test(input string name, input int err_at_start);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_at_start);
        end
    endtask

    initial begin
        rst = 1'b0;
        forever #5 rst = ~rst;
    end

    always @(posedge rst) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d words still expected",
                     cycle_cnt, exp_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    // output check and command memory model on the falling edge
    always @(negedge rst) begin
        credit_return = 1'b0;
        if (!clk) begin
            if (cmd_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected command word %h with no request pending", cmd);
                end else begin
                    check_value("cmd", exp_q.pop_front(), cmd);
                    check_value("seq_done", exp_last.pop_front(), seq_done);
                end
                assert (ds_q.size() < `MC_CREDITS) else begin
                    errors++;
                    $display("command memory overrun, word sent without a free slot");
                end
                ds_q.push_back(cmd);
            end else begin
                check_value("seq_done", 1'b0, seq_done); // only with a word
            end
            if (!req_ready) busy_seen = 1'b1;
            if (hold_cnt != 0) begin
                hold_cnt--; // credits withheld
            end else if (ds_q.size() != 0) begin
                case (drain_mode)
                    0: credit_return = 1'b1;
                    1: credit_return = (rand_bits(1) != 0);
                    default: begin
                        credit_return = 1'b1;
                        if (rand_bits(3) == 0) hold_cnt = 8 + int'(rand_bits(5));
                    end
                endcase
            end
            if (credit_return) void'(ds_q.pop_front()); // one slot freed per drained word
        end
    end

    initial begin
        int total;
        int err0;
        int prop_fails;
        clk = 1'b1;
        req = '0;
        req_valid = 1'b0;
        credit_return = 1'b0;
        lfsr = SEED;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        cycle_cnt = 0;
        hold_cnt = 0;
        drain_mode = 0;
        busy_seen = 1'b0;
        build_requests();
        total = 0;
        foreach (reqs[i]) total += ((reqs[i].num128 == '0) ? 64 : int'(reqs[i].num128)) + 8;
        cycle_limit = 4 * total + 200;
        repeat (2) @(posedge rst);
        @(negedge rst);
        clk = 1'b0;
        repeat (2) @(negedge rst);

        err0 = errors;
        check_value("req_ready", 1'b1, req_ready);
        check_value("cmd_valid", 1'b0, cmd_valid);
        check_value("seq_done", 1'b0, seq_done);
        report_test("reset state", err0);

        err0 = errors;
        send_req(reqs[0]);
        wait_drained();
        report_test("single burst", err0);

        err0 = errors;
        send_req(reqs[1]);
        send_req(reqs[2]);
        wait_drained();
        report_test("column wrap and 64 bursts", err0);

        err0 = errors;
        drain_mode = 1;
        busy_seen = 1'b0;
        for (int i = 3; i < 11; i++) send_req(reqs[i]);
        wait_drained();
        assert (busy_seen) else begin
            errors++;
            $display("req_ready never fell while all encoders were busy");
        end
        report_test("back-to-back random", err0);

        err0 = errors;
        drain_mode = 2;
        for (int i = 11; i < NUM_REQ; i++) send_req(reqs[i]);
        wait_drained();
        report_test("withheld credits", err0);

        prop_fails = int'(dut0.u_merge.u_props.fail_cnt);
        $display("tests run %0d, tests failing %0d, check errors %0d, property failures %0d",
                 tests_run, tests_bad, errors, prop_fails);
        if (errors == 0 && tests_bad == 0 && prop_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/mcontr_pkg.sv
logic/wr_req_dispatch.sv
logic/linear_wr_encoder.sv
logic/enc_cmd_merge.sv
logic/wr_seq_top.sv
tb/wr_seq_props.sv
tb/wr_seq_tb.sv
